//--- cacheTrace.txt
// Columns (hex): op, byte address, write data, byte mask, expected read data
// op 10 read miss, 11 read hit, 20 write miss, 21 write hit
10 00000000 00000000 0 A5A50000
11 00000008 00000000 0 A5A50002
21 00000004 11223344 3 00000000
11 00000004 00000000 0 A5A53344
20 00000030 CAFEBABE 9 00000000
11 00000030 00000000 0 CAA500BE
11 00000034 00000000 0 A5A5000D
// Set 0 eviction of the dirty block at 0x00, then re-read from memory
10 00000020 00000000 0 A5A50008
10 00000040 00000000 0 A5A50010
10 00000004 00000000 0 A5A53344
11 0000000C 00000000 0 A5A50003
// Set 1 eviction through a write miss, then refills of written-back blocks
21 00000038 55667788 F 00000000
10 00000050 00000000 0 A5A50014
20 00000074 0BADF00D 6 00000000
11 00000074 00000000 0 A5ADF01D
10 00000030 00000000 0 CAA500BE
11 00000038 00000000 0 55667788
11 0000003C 00000000 0 A5A5000F
10 00000010 00000000 0 A5A50004
10 00000074 00000000 0 A5ADF01D

//--- run.sh
#!/bin/sh
# Verilator build and run of the write-back cache testbench
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module cacheTb -f files.f -o cacheSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cacheSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Test completed successfully" "$logFile"; then
    exit 0
fi
echo "Pass message not found in $logFile"
exit 1

//--- files.f
cachePkg.sv
wordCounter.sv
cacheMemory.sv
cacheController.sv
dataWritebackCache.sv
cacheTb.sv

//--- cacheTb.sv
/* Trace-driven testbench for the write-back data cache, bsize 4 and lines 2
   Bus memory model covers byte addresses below 4 KiB, ack rise and fall delays 0 to 3 cycles */
`timescale 1ns/10ps

module cacheTb
    import cachePkg::*;
();

    localparam int bsize = 4;
    localparam int lines = 2;
    localparam int maxOps = 64;
    localparam int maxDelay = 3;
    localparam int memSize = 1024;
    localparam int memBits = 10;
    localparam string traceFile = "cacheTrace.txt";

    logic              clk, rst, enable, memWrite, memToReg;
    logic              stall, hRequest, hWrite;
    logic              hReady = 1'b0;
    logic [DATA_W-1:0] virtA, wd, rd, hAddr, hWData;
    logic [DATA_W-1:0] hRData = '0;
    logic [3:0]        byteMask;

    // Five words per trace line
    logic [31:0]       traceMem [maxOps*5];
    logic [DATA_W-1:0] busMem [memSize];
    logic [memSize-1:0] memWritten = '0;
    // Block base addresses the CPU has stored to since their last write-back
    logic [DATA_W-1:0] dirtyBlocks [$];
    logic [DATA_W-1:0] wbBase, reqAddr, reqData;
    logic [31:0]       rngState = 32'h8fe7b613;
    logic              reqActive = 1'b0;
    logic              prevReq = 1'b0;
    logic              reqWrite = 1'b0;
    int waitLeft = 0;
    int wbCount = 0;
    int reqCount = 0;
    int errorCount = 0;
    int passCount = 0;
    int failCount = 0;
    int cycleCount = 0;
    int cycleLimit = 0;
    int numOps = 0;

    dataWritebackCache #(.bsize(bsize), .lines(lines)) dut0 (
        .clk(clk), .rst(rst), .enable(enable), .memWrite(memWrite),
        .memToReg(memToReg), .hReady(hReady), .virtA(virtA), .wd(wd),
        .hRData(hRData), .byteMask(byteMask), .rd(rd), .hAddr(hAddr),
        .hWData(hWData), .stall(stall), .hRequest(hRequest), .hWrite(hWrite)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Contents of a word that was never written
    function automatic logic [DATA_W-1:0] memRule(input logic [DATA_W-1:0] addr);
        return {2'b00, addr[DATA_W-1:2]} ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [DATA_W-1:0] blockOf(input logic [DATA_W-1:0] addr);
        return addr & ~DATA_W'(4 * bsize - 1);
    endfunction

    task automatic checkWord(input string name, input logic [DATA_W-1:0] actual,
                             input logic [DATA_W-1:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s = %h, expected %h", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("error at %0t: %s = %b, expected %b", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic checkBus(input string name, input logic [DATA_W-1:0] actual,
                            input logic [DATA_W-1:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s = %h, expected %h", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    // First word of a burst must name a recorded dirty block, then words go in order
    task automatic trackWriteback(input logic [DATA_W-1:0] addr);
        int idx;
        idx = -1;
        if (wbCount == 0) begin
            wbBase = blockOf(addr);
            foreach (dirtyBlocks[j]) begin
                if (dirtyBlocks[j] == wbBase) begin
                    idx = j;
                end
            end
            if (idx < 0) begin
                $display("Write-back at %0t of block %h that the CPU never wrote",
                         $time, wbBase);
                errorCount++;
            end else begin
                dirtyBlocks.delete(idx);
            end
        end
        checkBus("hAddr", addr, wbBase + DATA_W'(4 * wbCount));
        wbCount = (wbCount + 1) % bsize;
    endtask

    // Bus memory model, four-phase slave with random ack rise and fall delays
    always @(posedge clk) begin
        if (rst) begin
            hReady <= 1'b0;
            reqActive = 1'b0;
            prevReq = 1'b0;
        end else begin
            if (hRequest && !prevReq) begin
                reqCount++;
                if (hReady) begin
                    $display("Bus request raised at %0t before the last ack was released",
                             $time);
                    errorCount++;
                end
            end
            if (hRequest && !hReady) begin
                if (!reqActive) begin
                    reqActive = 1'b1;
                    reqAddr = hAddr;
                    reqWrite = hWrite;
                    reqData = hWData;
                    rngState = xorshift32(rngState);
                    waitLeft = int'(rngState[1:0]);
                end else if (hAddr !== reqAddr || hWrite !== reqWrite ||
                             (hWrite && hWData !== reqData)) begin
                    $display("Bus address or data changed at %0t while waiting for ack",
                             $time);
                    errorCount++;
                end
                if (waitLeft == 0) begin
                    if (hAddr >= DATA_W'(4 * memSize)) begin
                        $display("Bus address %h at %0t is outside the memory model",
                                 hAddr, $time);
                        errorCount++;
                    end else if (hWrite) begin
                        trackWriteback(hAddr);
                        busMem[hAddr[2 +: memBits]] = hWData;
                        memWritten[hAddr[2 +: memBits]] = 1'b1;
                    end else if (memWritten[hAddr[2 +: memBits]]) begin
                        hRData <= busMem[hAddr[2 +: memBits]];
                    end else begin
                        hRData <= memRule(hAddr);
                    end
                    hReady <= 1'b1;
                    // Cycles hReady stays high after hRequest falls
                    rngState = xorshift32(rngState);
                    waitLeft = int'(rngState[1:0]);
                end else begin
                    waitLeft--;
                end
            end else if (!hRequest && hReady) begin
                // Slow release of the ack
                if (waitLeft == 0) begin
                    hReady <= 1'b0;
                    reqActive = 1'b0;
                end else begin
                    waitLeft--;
                end
            end else if (!hRequest && reqActive) begin
                $display("Bus request withdrawn at %0t before it was acknowledged", $time);
                errorCount++;
                reqActive = 1'b0;
            end
            prevReq = hRequest;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        logic [7:0]        opCode;
        logic [DATA_W-1:0] addr, wdata, expected;
        logic [3:0]        mask;
        logic              isWrite, expectHit, found;
        string             kind;
        int                base, waited, errBefore, reqBefore;
        clk = 1'b0;
        rst = 1'b1;
        enable = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        virtA = '0;
        wd = '0;
        byteMask = '0;
        foreach (traceMem[k]) begin
            traceMem[k] = '0;
        end
        $readmemh(traceFile, traceMem);
        // Op codes 10, 11, 20, 21 are valid, anything else ends the trace
        while (numOps < maxOps) begin
            opCode = traceMem[5 * numOps][7:0];
            if (opCode != 8'h10 && opCode != 8'h11 && opCode != 8'h20 && opCode != 8'h21) begin
                break;
            end
            numOps++;
        end
        if (numOps == 0) begin
            $display("No operations found in the trace");
            errorCount++;
        end
        cycleLimit = numOps * (2 * bsize) * (2 + maxDelay) + 100;

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        errBefore = errorCount;
        checkFlag("hRequest", hRequest, 1'b0);
        checkFlag("stall", stall, 1'b0);
        if (errorCount == errBefore) begin
            $display("reset check: ok");
        end else begin
            $display("reset check: FAILED");
        end

        for (int i = 0; i < numOps; i++) begin
            base = 5 * i;
            opCode = traceMem[base][7:0];
            addr = traceMem[base + 1];
            wdata = traceMem[base + 2];
            mask = traceMem[base + 3][3:0];
            expected = traceMem[base + 4];
            isWrite = (opCode[7:4] == 4'h2);
            expectHit = opCode[0];
            if (isWrite) begin
                kind = "write";
            end else begin
                kind = "read";
            end
            errBefore = errorCount;
            reqBefore = reqCount;
            // Stored blocks become write-back candidates
            if (isWrite) begin
                found = 1'b0;
                foreach (dirtyBlocks[j]) begin
                    if (dirtyBlocks[j] == blockOf(addr)) begin
                        found = 1'b1;
                    end
                end
                if (!found) begin
                    dirtyBlocks.push_back(blockOf(addr));
                end
            end
            enable <= 1'b1;
            memWrite <= isWrite;
            memToReg <= ~isWrite;
            virtA <= addr;
            wd <= wdata;
            byteMask <= mask;
            waited = 0;
            @(posedge clk);
            while (stall) begin
                waited++;
                @(posedge clk);
            end
            if (!isWrite) begin
                checkWord("rd", rd, expected);
            end
            if (expectHit && (waited != 0 || reqCount != reqBefore)) begin
                $display("Operation %0d was expected to hit but stalled or used the bus", i);
                errorCount++;
            end
            if (!expectHit && reqCount == reqBefore) begin
                $display("Operation %0d was expected to miss but made no bus request", i);
                errorCount++;
            end
            if (errorCount == errBefore) begin
                passCount++;
                $display("op %0d %s at %h: ok after %0d stall cycles", i, kind, addr, waited);
            end else begin
                failCount++;
                $display("op %0d %s at %h: FAILED", i, kind, addr);
            end
        end
        enable <= 1'b0;
        memWrite <= 1'b0;
        memToReg <= 1'b0;
        @(posedge clk);

        $display("Summary: %0d operations passed, %0d failed, %0d errors in total",
                 passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- dataWritebackCache.sv
/* Two-way write-back data cache, write-allocate, LRU replacement
   CPU holds its request while stall is high; lines must be at least 2
   Virtual tag is used as the physical tag, no TLB */
`timescale 1ns/10ps

module dataWritebackCache
    import cachePkg::*;
#(
    parameter int bsize = 4,
    parameter int lines = 2,
    localparam int setBits = $clog2(lines),
    localparam int blockBits = $clog2(bsize),
    localparam int tagBits = 30 - blockBits - setBits
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              enable,
    input  logic              memWrite,
    input  logic              memToReg,
    input  logic              hReady,
    input  logic [DATA_W-1:0] virtA,
    input  logic [DATA_W-1:0] wd,
    input  logic [DATA_W-1:0] hRData,
    input  logic [3:0]        byteMask,
    output logic [DATA_W-1:0] rd,
    output logic [DATA_W-1:0] hAddr,
    output logic [DATA_W-1:0] hWData,
    output logic              stall,
    output logic              hRequest,
    output logic              hWrite
);

    // Address fields of the CPU request
    logic [tagBits-1:0]   cpuTag;
    logic [tagBits-1:0]   victimTag;
    logic [setBits-1:0]   setIdx;
    logic [blockBits-1:0] cpuWord;
    logic [blockBits-1:0] wordOff;
    logic [blockBits-1:0] wordSel;

    // Way data paths
    logic [DATA_W-1:0] w1Rd;
    logic [DATA_W-1:0] w2Rd;
    logic [DATA_W-1:0] victimRd;
    logic [DATA_W-1:0] hitWord;
    logic [DATA_W-1:0] baseWord;
    logic [DATA_W-1:0] wayWData;
    logic [ADDR_W-1:0] fillAddr;
    logic [ADDR_W-1:0] victimAddr;
    logic [3:0]        wdSel;

    // Controller and memory handshake
    logic hit1, hit2, lruWay, victimDirty, lastWord, cpuWordSel;
    logic useVictimAddr, cntClr, cntInc, w1We, w2We;
    logic blockWe, dirtyIn, lruUpdate, fillWay;

    assign cpuTag  = virtA[ADDR_W-1 -: tagBits];
    assign setIdx  = virtA[2+blockBits +: setBits];
    assign cpuWord = virtA[2 +: blockBits];

    // Burst offset while stalled, CPU word otherwise
    assign wordSel    = stall ? wordOff : cpuWord;
    assign cpuWordSel = (wordOff == cpuWord);

    // Refill and write-back addresses share set and offset
    assign fillAddr   = {cpuTag, setIdx, wordOff, 2'b00};
    assign victimAddr = {victimTag, setIdx, wordOff, 2'b00};
    assign hAddr      = useVictimAddr ? victimAddr : fillAddr;

    // Way select for loads and hit merges
    assign hitWord = hit2 ? w2Rd : w1Rd;
    assign rd      = hitWord;
    assign hWData  = victimRd;

    // Fill words come from the bus, hit writes keep the stored bytes
    assign baseWord = stall ? hRData : hitWord;

    // Per-byte merge of the store data
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            // During a fill only the stalled store's word takes wd bytes
            wdSel[b] = byteMask[b] & memWrite & (~stall | cpuWordSel);
            wayWData[8*b +: 8] = wdSel[b] ? wd[8*b +: 8] : baseWord[8*b +: 8];
        end
    end

    cacheController ctrl0 (
        .clk(clk), .rst(rst), .enable(enable), .memWrite(memWrite),
        .memToReg(memToReg), .hit1(hit1), .hit2(hit2), .lruWay(lruWay),
        .victimDirty(victimDirty), .hReady(hReady), .lastWord(lastWord),
        .cpuWordSel(cpuWordSel), .stall(stall), .hRequest(hRequest),
        .hWrite(hWrite), .useVictimAddr(useVictimAddr), .cntClr(cntClr),
        .cntInc(cntInc), .w1We(w1We), .w2We(w2We), .blockWe(blockWe),
        .dirtyIn(dirtyIn), .lruUpdate(lruUpdate), .fillWay(fillWay)
    );

    cacheMemory #(.lines(lines), .bsize(bsize)) mem0 (
        .clk(clk), .rst(rst), .w1We(w1We), .w2We(w2We), .blockWe(blockWe),
        .dirtyIn(dirtyIn), .lruUpdate(lruUpdate), .fillWay(fillWay),
        .set(setIdx), .wordSel(wordSel), .tag(cpuTag), .wdata(wayWData),
        .hit1(hit1), .hit2(hit2), .lruWay(lruWay), .victimDirty(victimDirty),
        .victimTag(victimTag), .w1Rd(w1Rd), .w2Rd(w2Rd), .victimRd(victimRd)
    );

    wordCounter #(.bsize(bsize)) cnt0 (
        .clk(clk), .rst(rst), .cntClr(cntClr), .cntInc(cntInc),
        .wordOff(wordOff), .lastWord(lastWord)
    );

endmodule

//--- cacheController.sv
/* Miss handler: optional write-back burst, then fill burst, one word per
   four-phase handshake; memory must drop hReady after hRequest falls */
`timescale 1ns/10ps

module cacheController
    import cachePkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  logic memWrite,
    input  logic memToReg,
    input  logic hit1,
    input  logic hit2,
    input  logic lruWay,
    input  logic victimDirty,
    input  logic hReady,
    input  logic lastWord,
    input  logic cpuWordSel,
    output logic stall,
    output logic hRequest,
    output logic hWrite,
    output logic useVictimAddr,
    output logic cntClr,
    output logic cntInc,
    output logic w1We,
    output logic w2We,
    output logic blockWe,
    output logic dirtyIn,
    output logic lruUpdate,
    output logic fillWay
);

    cacheState_t state;
    cacheState_t nextState;
    logic        victimWay;
    logic        req;
    logic        miss;

    assign req  = enable & (memWrite | memToReg);
    assign miss = req & ~(hit1 | hit2);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // Victim way frozen for the whole miss
    always_ff @(posedge clk) begin
        if (rst) begin
            victimWay <= 1'b0;
        end else if (state == IDLE && miss) begin
            victimWay <= lruWay;
        end
    end

    always_comb begin
        nextState     = state;
        stall         = 1'b1;
        hRequest      = 1'b0;
        hWrite        = 1'b0;
        useVictimAddr = 1'b0;
        cntClr        = 1'b0;
        cntInc        = 1'b0;
        w1We          = 1'b0;
        w2We          = 1'b0;
        blockWe       = 1'b0;
        dirtyIn       = 1'b0;
        lruUpdate     = 1'b0;
        fillWay       = victimWay;
        case (state)
            IDLE: begin
                // Victim not latched yet, follow the LRU bit
                fillWay = lruWay;
                stall   = miss;
                if (req && !miss) begin
                    lruUpdate = 1'b1;
                    if (memWrite) begin
                        w1We    = hit1;
                        w2We    = hit2;
                        dirtyIn = 1'b1;
                    end
                end else if (miss) begin
                    cntClr    = 1'b1;
                    nextState = victimDirty ? WB_REQ : FILL_REQ;
                end
            end
            WB_REQ: begin
                hRequest      = 1'b1;
                hWrite        = 1'b1;
                useVictimAddr = 1'b1;
                if (hReady) begin
                    nextState = WB_REL;
                end
            end
            WB_REL: begin
                useVictimAddr = 1'b1;
                // Wait for ack low before next word
                if (!hReady) begin
                    cntInc    = 1'b1;
                    nextState = lastWord ? FILL_REQ : WB_REQ;
                end
            end
            FILL_REQ: begin
                hRequest = 1'b1;
                if (hReady) begin
                    // Capture bus word into the victim way
                    w1We      = ~victimWay;
                    w2We      = victimWay;
                    blockWe   = lastWord;
                    // Dirty once the store's bytes land, kept at tag install
                    dirtyIn   = memWrite & (cpuWordSel | lastWord);
                    nextState = FILL_REL;
                end
            end
            FILL_REL: begin
                if (!hReady) begin
                    cntInc    = 1'b1;
                    nextState = lastWord ? IDLE : FILL_REQ;
                end
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    // Request held until memory acknowledges
    reqHeld: assert property (@(posedge clk) disable iff (rst)
        $fell(hRequest) |-> $past(hReady));

    // New request only after the previous ack has gone
    reqAfterRelease: assert property (@(posedge clk) disable iff (rst)
        $rose(hRequest) |-> !hReady);

    oneWayWrite: assert property (@(posedge clk) disable iff (rst)
        !(w1We && w2We));

endmodule

//--- cacheMemory.sv
/* Two ways of tag, valid, dirty and data with one LRU bit per set
   Victim tag and data follow fillWay; tag and data arrays have no reset */
`timescale 1ns/10ps

module cacheMemory
    import cachePkg::*;
#(
    parameter int lines = 2,
    parameter int bsize = 4,
    localparam int setBits = $clog2(lines),
    localparam int blockBits = $clog2(bsize),
    localparam int tagBits = 30 - blockBits - setBits
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 w1We,
    input  logic                 w2We,
    input  logic                 blockWe,
    input  logic                 dirtyIn,
    input  logic                 lruUpdate,
    input  logic                 fillWay,
    input  logic [setBits-1:0]   set,
    input  logic [blockBits-1:0] wordSel,
    input  logic [tagBits-1:0]   tag,
    input  logic [DATA_W-1:0]    wdata,
    output logic                 hit1,
    output logic                 hit2,
    output logic                 lruWay,
    output logic                 victimDirty,
    output logic [tagBits-1:0]   victimTag,
    output logic [DATA_W-1:0]    w1Rd,
    output logic [DATA_W-1:0]    w2Rd,
    output logic [DATA_W-1:0]    victimRd
);

    // Index 0 is way 1, index 1 is way 2
    logic [DATA_W-1:0]  dataMem [2][lines][bsize];
    logic [tagBits-1:0] tagMem  [2][lines];
    logic [lines-1:0]   valid   [2];
    logic [lines-1:0]   dirty   [2];
    // Set bit names the way to replace next
    logic [lines-1:0]   lru;
    logic [1:0]         wayWe;
    logic [1:0]         wayHit;

    assign wayWe = {w2We, w1We};

    // Tag compare per way
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayHit[w] = valid[w][set] && (tagMem[w][set] == tag);
        end
    end

    assign hit1 = wayHit[0];
    assign hit2 = wayHit[1];
    assign w1Rd = dataMem[0][set][wordSel];
    assign w2Rd = dataMem[1][set][wordSel];

    // Victim view
    assign lruWay      = lru[set];
    assign victimDirty = valid[lruWay][set] & dirty[lruWay][set];
    assign victimTag   = tagMem[fillWay][set];
    assign victimRd    = dataMem[fillWay][set][wordSel];

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wayWe[w]) begin
                dataMem[w][set][wordSel] <= wdata;
            end
        end
        // New tag installed with the last fill word
        if (blockWe) begin
            tagMem[fillWay][set] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < 2; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
            lru <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wayWe[w] && dirtyIn) begin
                    dirty[w][set] <= 1'b1;
                end
            end
            if (blockWe) begin
                valid[fillWay][set] <= 1'b1;
                dirty[fillWay][set] <= dirtyIn;
            end
            // Hit in way 1 makes way 2 the next victim
            if (lruUpdate) begin
                lru[set] <= wayHit[0];
            end
        end
    end

    // A block lives in at most one way of its set
    for (genvar s = 0; s < lines; s++) begin : gNoAlias
        noDupTag: assert property (@(posedge clk) disable iff (rst)
            !(valid[0][s] && valid[1][s] && tagMem[0][s] == tagMem[1][s]));
    end

endmodule

//--- wordCounter.sv
/* Word offset within a block for write-back and fill bursts
   bsize must be a power of two, offset wraps to zero after the last word */
`timescale 1ns/10ps

module wordCounter #(
    parameter int bsize = 4,
    localparam int blockBits = $clog2(bsize)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cntClr,
    input  logic                 cntInc,
    output logic [blockBits-1:0] wordOff,
    output logic                 lastWord
);

    always_ff @(posedge clk) begin
        if (rst) begin
            wordOff <= '0;
        end else if (cntClr) begin
            // Start of a miss
            wordOff <= '0;
        end else if (cntInc) begin
            // One step per acknowledged word
            wordOff <= wordOff + 1'b1;
        end
    end

    // Terminal word of the burst
    assign lastWord = (wordOff == blockBits'(bsize - 1));

endmodule

//--- cachePkg.sv
/* Shared widths and miss-handler states for the write-back data cache
   Byte addresses, 32-bit words, accesses are word aligned */
package cachePkg;

    // Byte address width
    localparam int ADDR_W = 32;

    // CPU and bus word width
    localparam int DATA_W = 32;

    // Miss handler states
    typedef enum logic [2:0] {
        // Serving hits
        IDLE,
        // Write-back word, request high
        WB_REQ,
        // Write-back word, request released
        WB_REL,
        // Fill word, request high
        FILL_REQ,
        // Fill word, request released
        FILL_REL
    } cacheState_t;

endpackage
